// File: memCtrl_stim.txt
// test write io addr data expAck expNxm expData, all hex, one bus cycle per line
// Lines are issued back to back, test number ff ends the list
01 0 1 08000 000000000 1 0 080800000
02 1 1 08000 FFFFFFFFF 1 0 000000000
02 0 1 08000 000000000 1 0 100800000
02 1 1 08000 FFF7FFFFF 1 0 000000000
02 0 1 08000 000000000 1 0 100000000
02 1 1 08000 000800000 1 0 000000000
02 0 1 08000 000000000 1 0 080000000
02 1 1 08000 000000001 1 0 000000000
02 0 1 08000 000000000 1 0 000000000
03 1 0 00010 123456789 1 0 000000000
03 0 0 00010 000000000 1 0 123456789
03 1 0 00011 ABCDEF012 1 0 000000000
03 1 0 00012 0F0F0F0F0 1 0 000000000
03 0 0 00011 000000000 1 0 ABCDEF012
03 0 0 00012 000000000 1 0 0F0F0F0F0
03 1 0 003FF 876543210 1 0 000000000
03 0 0 003FF 000000000 1 0 876543210
03 1 0 00010 111111111 1 0 000000000
03 0 0 00010 000000000 1 0 111111111
04 1 0 00000 555555555 1 0 000000000
04 1 0 00400 DEADBEEF0 1 1 000000000
04 0 0 00000 000000000 1 0 555555555
04 0 0 00400 000000000 1 1 000000000
04 0 0 FFFFF 000000000 1 1 000000000
04 0 0 08000 000000000 1 1 000000000
04 1 0 00005 2468ACE02 1 0 000000000
04 1 0 80005 13579BDF1 1 1 000000000
04 0 0 00005 000000000 1 0 2468ACE02
05 0 0 00010 000000000 1 0 111111111
05 0 1 00200 000000000 0 0 000000000
05 0 0 00011 000000000 1 0 ABCDEF012
05 1 1 08001 FFFFFFFFF 0 0 000000000
05 0 1 08000 000000000 1 0 000000000
05 1 1 00000 FFFFFFFFF 0 0 000000000
05 0 0 00012 000000000 1 0 0F0F0F0F0
ff 0 0 00000 000000000 0 0 000000000

// File: project.f
memPkg.sv
memBusDecode.sv
memArray.sv
memStatReg.sv
memRespond.sv
memCtrl.sv
memCtrl_chk.sv
memCtrl_tb.sv

// File: Makefile
# Verilator build and run for the memCtrl testbench

SRCS := $(shell cat project.f)

obj_dir/VmemCtrl_tb: project.f $(SRCS)
	verilator --binary --assert -j 0 --top-module memCtrl_tb -f project.f

run: obj_dir/VmemCtrl_tb
	@out="$$(./obj_dir/VmemCtrl_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: memCtrl_tb.sv
// Testbench for memCtrl with stim file playback, LCG data sweep, watchdog and test report
`default_nettype none

module memCtrl_tb import memPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int stimFields  = 8;
   localparam int maxLines    = 64;
   localparam int resetCycles = 16;
   localparam int sweepWords  = 64;
   localparam int sweepTest   = 6;
   localparam int pipeDepth   = 3;

   // Expected response of one issued bus cycle
   typedef struct packed
   {
      logic [7:0]           test;
      logic                 ack;
      logic                 nxm;
      logic [0:wordWidth-1] data;
   } respExp_t;

   logic                 clk;
   logic                 rst;
   busReq_t              busReq;
   busResp_t             busResp;
   logic [39:0]          stimMem [stimFields*maxLines];
   logic [0:wordWidth-1] model [memWords];
   respExp_t             expQ [$];
   logic                 stimLoaded;
   int                   stimLines;
   int                   curTest;
   int                   testErrors;
   int                   errorCount;
   int                   testsPassed;
   int                   testsFailed;

   memCtrl i_memCtrl
   (
      .clk     (clk),
      .rst     (rst),
      .busReq  (busReq),
      .busResp (busResp)
   );

   ////////////////////////////////////////////////////////////
   // Clock and watchdog
   ////////////////////////////////////////////////////////////

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #10 clk = ~clk;
      end
   end

   // Budget covers stim lines, both sweep passes, reset, the drain and a margin
   initial
   begin
      int timeoutCycles;
      wait (stimLoaded === 1'b1);
      timeoutCycles = stimLines + 2 * sweepWords + resetCycles + pipeDepth + 100;
      repeat (timeoutCycles)
      begin
         #20;
      end
      $display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
      $display("Simulation FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   // Numerical Recipes LCG step
   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic respExp_t makeExp(input logic [7:0] test, input logic ack,
                                        input logic nxm, input logic [0:wordWidth-1] data);
      respExp_t e;
      e.test = test;
      e.ack  = ack;
      e.nxm  = nxm;
      e.data = data;
      return e;
   endfunction

   // One report line per test number
   task automatic finishTest();
      if (curTest != 0)
      begin
         if (testErrors == 0)
         begin
            $display("Test %0d passed", curTest);
            testsPassed++;
         end
         else
         begin
            $display("Test %0d failed with %0d errors", curTest, testErrors);
            testsFailed++;
         end
      end
      testErrors = 0;
   endtask

   task automatic checkResp(input respExp_t want);
      int errs;
      errs = 0;
      if (int'(want.test) != curTest)
      begin
         finishTest();
         curTest = int'(want.test);
      end
      if (busResp.ack !== want.ack)
      begin
         $display("[FAIL] %0d ns test %0d: ack %0b, expected %0b", $time, want.test,
                  busResp.ack, want.ack);
         errs++;
      end
      if (busResp.nxm !== want.nxm)
      begin
         $display("[FAIL] %0d ns test %0d: nxm %0b, expected %0b", $time, want.test,
                  busResp.nxm, want.nxm);
         errs++;
      end
      // Unacknowledged slots carry zero data
      if (busResp.data !== want.data)
      begin
         $display("[FAIL] %0d ns test %0d: data %09h, expected %09h", $time, want.test,
                  busResp.data, want.data);
         errs++;
      end
      testErrors += errs;
      errorCount += errs;
   endtask

   // Slot issued three cycles ago is checked before the new cycle is driven
   task automatic issueCycle(input logic write, input logic io,
                             input logic [addrWidth-1:0] addr,
                             input logic [0:wordWidth-1] data, input respExp_t want);
      @(posedge clk);
      #2;
      if (expQ.size() == pipeDepth)
      begin
         checkResp(expQ.pop_front());
      end
      busReq.req   = 1'b1;
      busReq.write = write;
      busReq.io    = io;
      busReq.addr  = addr;
      busReq.data  = data;
      expQ.push_back(want);
   endtask

   task automatic drainPipe();
      while (expQ.size() > 0)
      begin
         @(posedge clk);
         #2;
         busReq = '0;
         checkResp(expQ.pop_front());
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial
   begin
      respExp_t             want;
      logic [31:0]          seed;
      logic [31:0]          hi;
      logic [0:wordWidth-1] word;
      logic [addrWidth-1:0] addr;
      int                   base;

      rst         = 1'b1;
      busReq      = '0;
      stimLoaded  = 1'b0;
      curTest     = 0;
      testErrors  = 0;
      errorCount  = 0;
      testsPassed = 0;
      testsFailed = 0;
      seed        = 32'h45f1;

      // Eight fields per line and test number ff ends the list
      $readmemh("memCtrl_stim.txt", stimMem);
      stimLines = 0;
      while ((stimLines < maxLines) && (stimMem[stimLines*stimFields][7:0] !== 8'hff))
      begin
         stimLines++;
      end
      if ((stimLines == 0) || (stimLines == maxLines))
      begin
         $display("Stimulus file memCtrl_stim.txt is empty or has no end marker");
         errorCount++;
         stimLines = 0;
      end
      stimLoaded = 1'b1;

      repeat (resetCycles)
      begin
         @(posedge clk);
      end
      #2;
      rst = 1'b0;

      // Directed cycles back to back
      for (int i = 0; i < stimLines; i++)
      begin
         base = i * stimFields;
         want = makeExp(stimMem[base][7:0], stimMem[base+5][0], stimMem[base+6][0],
                        stimMem[base+7][35:0]);
         issueCycle(stimMem[base+1][0], stimMem[base+2][0], stimMem[base+3][19:0],
                    stimMem[base+4][35:0], want);
      end

      // Random words on a stride of 7 with the model keeping what was written
      for (int i = 0; i < sweepWords; i++)
      begin
         seed = lcgNext(seed);
         hi   = seed;
         seed = lcgNext(seed);
         word = {hi[31:28], seed};
         addr = 20'h00100 + 20'(i * 7);
         model[addr[memAddrWidth-1:0]] = word;
         want = makeExp(8'(sweepTest), 1'b1, 1'b0, '0);
         issueCycle(1'b1, 1'b0, addr, word, want);
      end
      for (int i = 0; i < sweepWords; i++)
      begin
         addr = 20'h00100 + 20'(i * 7);
         want = makeExp(8'(sweepTest), 1'b1, 1'b0, model[addr[memAddrWidth-1:0]]);
         issueCycle(1'b0, 1'b0, addr, '0, want);
      end

      drainPipe();
      finishTest();
      $display("Tests passed: %0d, tests failed: %0d, check errors: %0d", testsPassed,
               testsFailed, errorCount);
      if ((errorCount == 0) && (testsFailed == 0))
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: memCtrl_chk.sv
// Concurrent assertions on the memCtrl request and response, with the bind into memCtrl
`default_nettype none

module memCtrl_chk import memPkg::*;
(
   input logic     clk,
   input logic     rst,
   input busReq_t  busReq,
   input busResp_t busResp
);
   timeunit 1ns;
   timeprecision 100ps;

   // Request that decodes to a real operation
   // Memory space always counts, IO only at the MSR
   logic validReq;

   always_comb
   begin
      validReq = busReq.req && (!busReq.io || (busReq.addr == msrAddr));
   end

   ////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////

   // Response register is cleared while reset is held
   ackLowInReset: assert property (@(posedge clk) rst |=> !busResp.ack)
      else $error("ack went high during reset");

   // Fixed latency of three cycles
   ackAfterReq: assert property (@(posedge clk) disable iff (rst) validReq |-> ##3 busResp.ack)
      else $error("valid request not acknowledged three cycles later");

   // And no ack without such a request
   ackHasReq: assert property (@(posedge clk) disable iff (rst)
                               busResp.ack |-> $past(validReq, 3))
      else $error("ack without a valid request three cycles earlier");

   nxmNeedsAck: assert property (@(posedge clk) busResp.nxm |-> busResp.ack)
      else $error("nxm set without ack");

endmodule

bind memCtrl memCtrl_chk i_memCtrl_chk
(
   .clk     (clk),
   .rst     (rst),
   .busReq  (busReq),
   .busResp (busResp)
);

`default_nettype wire

// File: memCtrl.sv
// Memory controller top with decode, array, MSR and response stages and the stage 2 register
`default_nettype none

module memCtrl import memPkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  busReq_t  busReq,
   output busResp_t busResp
);

   memStage_t            stage1;
   memStage_t            stage2;
   logic [0:wordWidth-1] rdData;
   logic [0:wordWidth-1] regStat;

   // Stage 1, decode
   memBusDecode i_memBusDecode
   (
      .clk    (clk),
      .rst    (rst),
      .busReq (busReq),
      .stage1 (stage1)
   );

   // Stage 2, array access
   memArray i_memArray
   (
      .clk    (clk),
      .stage1 (stage1),
      .rdData (rdData)
   );

   // Stage 2, status register access
   memStatReg i_memStatReg
   (
      .clk     (clk),
      .rst     (rst),
      .stage1  (stage1),
      .regStat (regStat)
   );

   ////////////////////////////////////////////////////////////
   // Stage 2 register
   ////////////////////////////////////////////////////////////

   // Lines the operation up with the array read data
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         stage2.op  <= opNone;
         stage2.nxm <= 1'b0;
      end
      else
      begin
         stage2.op  <= stage1.op;
         stage2.nxm <= stage1.nxm;
      end
   end

   always_ff @(posedge clk)
   begin
      stage2.addr <= stage1.addr;
      stage2.data <= stage1.data;
   end

   // Stage 3, response
   memRespond i_memRespond
   (
      .clk     (clk),
      .rst     (rst),
      .stage2  (stage2),
      .rdData  (rdData),
      .regStat (regStat),
      .busResp (busResp)
   );

endmodule

`default_nettype wire

// File: memRespond.sv
// Stage 3 response register for acknowledge, NXM flag and selected read data
`default_nettype none

module memRespond import memPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  memStage_t            stage2,
   input  logic [0:wordWidth-1] rdData,
   input  logic [0:wordWidth-1] regStat,
   output busResp_t             busResp
);

   ////////////////////////////////////////////////////////////
   // Response selection
   ////////////////////////////////////////////////////////////

   busResp_t nextResp;

   always_comb
   begin
      nextResp.ack  = (stage2.op != opNone);
      nextResp.nxm  = stage2.nxm;
      nextResp.data = '0;
      unique case (stage2.op)
         opMemRead:
         begin
            // NXM reads return zero
            if (!stage2.nxm)
            begin
               nextResp.data = rdData;
            end
         end
         opStatRead:
         begin
            nextResp.data = regStat;
         end
         default:
         begin
            // Writes and idle cycles carry no data
            nextResp.data = '0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busResp <= '0;
      end
      else
      begin
         busResp <= nextResp;
      end
   end

endmodule

`default_nettype wire

// File: memStatReg.sv
// Stage 2 Memory Status Register with PE, PF and EE bits and the assembled status word
`default_nettype none

module memStatReg import memPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  memStage_t            stage1,
   output logic [0:wordWidth-1] regStat
);

   ////////////////////////////////////////////////////////////
   // Status bits
   ////////////////////////////////////////////////////////////

   // Parity error, plain read and write
   logic statPe;

   // Power fail, comes up set
   logic statPf;

   // ECC enable, inverse of the last ED written
   logic statEe;

   logic msrWrite;

   always_comb
   begin
      msrWrite = (stage1.op == opStatWrite);
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         statPe <= 1'b0;
         statPf <= 1'b1;
         statEe <= 1'b1;
      end
      else if (msrWrite)
      begin
         statPe <= stage1.data[msrPeBit];
         // A written 1 never sets PF again
         statPf <= statPf & stage1.data[msrPfBit];
         statEe <= ~stage1.data[msrEdBit];
      end
   end

   ////////////////////////////////////////////////////////////
   // Read word
   ////////////////////////////////////////////////////////////

   // EH, UE, RE, ECP, ERA and FCB are not built, they read 0
   always_comb
   begin
      regStat           = '0;
      regStat[msrPeBit] = statPe;
      regStat[msrEeBit] = statEe;
      regStat[msrPfBit] = statPf;
   end

endmodule

`default_nettype wire

// File: memArray.sv
// Stage 2 word array with synchronous write and registered read data
`default_nettype none

module memArray import memPkg::*;
(
   input  logic                 clk,
   input  memStage_t            stage1,
   output logic [0:wordWidth-1] rdData
);

   ////////////////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////////////////

   // One KS10 word per entry
   logic [0:wordWidth-1] mem [memWords];

   // Write enable
   // Only a real memory write inside the array stores
   logic wrEn;

   always_comb
   begin
      wrEn = (stage1.op == opMemWrite) && !stage1.nxm;
   end

   ////////////////////////////////////////////////////////////
   // Write port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (wrEn)
      begin
         mem[stage1.addr] <= stage1.data;
      end
   end

   ////////////////////////////////////////////////////////////
   // Read port
   ////////////////////////////////////////////////////////////

   // Addressed word is registered every cycle
   // Old contents come out on the cycle of a write to the same word
   // A read one cycle behind a write sees the new word
   always_ff @(posedge clk)
   begin
      rdData <= mem[stage1.addr];
   end

endmodule

`default_nettype wire

// File: memBusDecode.sv
// Stage 1 bus request decoder with NXM detection and registered operation
`default_nettype none

module memBusDecode import memPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  busReq_t   busReq,
   output memStage_t stage1
);

   ////////////////////////////////////////////////////////////
   // Request classification
   ////////////////////////////////////////////////////////////

   memOp_t nextOp;
   logic   nextNxm;

   always_comb
   begin
      nextOp  = opNone;
      nextNxm = 1'b0;
      if (busReq.req)
      begin
         if (!busReq.io)
         begin
            // Memory space, size check against the array
            nextOp  = busReq.write ? opMemWrite : opMemRead;
            nextNxm = (busReq.addr >= addrWidth'(memWords));
         end
         else if (busReq.addr == msrAddr)
         begin
            // MSR is the only IO register here
            nextOp = busReq.write ? opStatWrite : opStatRead;
         end
         // Any other IO address stays opNone and gets no ack
      end
   end

   ////////////////////////////////////////////////////////////
   // Stage 1 register
   ////////////////////////////////////////////////////////////

   // Control part, idle after reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         stage1.op  <= opNone;
         stage1.nxm <= 1'b0;
      end
      else
      begin
         stage1.op  <= nextOp;
         stage1.nxm <= nextNxm;
      end
   end

   // Payload part
   // Address is cut down to the array index, NXM already covers the rest
   always_ff @(posedge clk)
   begin
      stage1.addr <= busReq.addr[memAddrWidth-1:0];
      stage1.data <= busReq.data;
   end

endmodule

`default_nettype wire

// File: memPkg.sv
// Widths, MSR address and bit positions, operation enum and pipeline structs
`default_nettype none

package memPkg;

   ////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////

   // KS10 word, bit 0 is the most significant
   localparam int wordWidth    = 36;

   // Physical address on the bus
   localparam int addrWidth    = 20;

   // On-chip array index
   localparam int memAddrWidth = 10;

   // Array size in words, addresses at or above this are NXM
   localparam int memWords     = 1 << memAddrWidth;

   ////////////////////////////////////////////////////////////
   // Memory Status Register
   ////////////////////////////////////////////////////////////

   // The only IO address this slice answers
   localparam logic [addrWidth-1:0] msrAddr = 20'o100000;

   // Bit positions in the 0..35 word numbering
   // Parity error, read and write
   localparam int msrPeBit = 3;

   // ECC enable, reads back the inverse of ED
   localparam int msrEeBit = 4;

   // Power fail, set at reset and cleared by writing 0
   localparam int msrPfBit = 12;

   // ECC disable, write only
   localparam int msrEdBit = 35;

   ////////////////////////////////////////////////////////////
   // Operations and pipeline records
   ////////////////////////////////////////////////////////////

   // Decoded bus cycle
   typedef enum logic [2:0]
   {
      opNone,
      opMemRead,
      opMemWrite,
      opStatRead,
      opStatWrite
   } memOp_t;

   // Processor side request, req is a one cycle strobe
   typedef struct packed
   {
      logic                 req;
      logic                 write;
      logic                 io;
      logic [addrWidth-1:0] addr;
      logic [0:wordWidth-1] data;
   } busReq_t;

   // Stage 1 result carried into stages 2 and 3
   typedef struct packed
   {
      memOp_t                  op;
      logic                    nxm;
      logic [memAddrWidth-1:0] addr;
      logic [0:wordWidth-1]    data;
   } memStage_t;

   // Response back to the processor, ack is a one cycle pulse
   typedef struct packed
   {
      logic                 ack;
      logic                 nxm;
      logic [0:wordWidth-1] data;
   } busResp_t;

endpackage

`default_nettype wire
